//--- cache_top.f
verilog/cache_pkg.sv
verilog/cache_way.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
sim/cache_asserts.sv
sim/tb_cache.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator, pass only on the pass line

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_cache \
    -f cache_top.f -o sim_cache > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_cache > sim.log 2>&1

grep -q "TEST RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- sim/cache_asserts.sv
`timescale 1ns/10ps
// handshake assertions, bound onto cache_top

module cache_asserts
    import cache_pkg::*;
(
    input logic              clk,
    input logic              rst_n,
    input logic              req_valid,
    input logic              req_ready,
    input logic              resp_valid,
    input logic              mem_req_valid,
    input logic              mem_req_ready,
    input logic              mem_req_write,
    input logic [addr_w-1:0] mem_req_addr,
    input logic [line_w-1:0] mem_wdata
);

    // back-pressure keeps the memory request frozen
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_write)
            && $stable(mem_req_addr) && $stable(mem_wdata))
        else $error("memory request changed while stalled");

    assert property (@(posedge clk) disable iff (!rst_n) resp_valid |=> !resp_valid)
        else $error("resp_valid high for two cycles");

    assert property (@(posedge clk) disable iff (!rst_n) req_valid && req_ready |=> !req_ready)
        else $error("req_ready high right after acceptance");

    assert property (@(posedge clk) disable iff (!rst_n) !req_ready && !resp_valid |=> !req_ready)
        else $error("req_ready rose before the response");

endmodule

bind cache_top cache_asserts asrt0 (.*);

//--- sim/tb_cache.sv
`timescale 1ns/10ps
// directed testbench for the two-way cache with a line memory model under random
// back-pressure, a shadow tag and LRU model and a flat reference of memory contents

module tb_cache
    import cache_pkg::*;
;
    localparam int clk_period = 40;
    localparam int random_reqs = 200;
    localparam int total_reqs = 9 + random_reqs;   // directed requests plus the random run
    localparam int max_wait = 200;

    logic clk;
    logic rst_n;
    logic req_valid, req_write;
    logic [addr_w-1:0] req_addr;
    logic [data_w-1:0] req_wdata;
    logic req_ready, resp_valid, resp_hit;
    logic [data_w-1:0] resp_rdata;
    logic mem_req_valid, mem_req_write, mem_req_ready, mem_resp_valid;
    logic [addr_w-1:0] mem_req_addr;
    logic [line_w-1:0] mem_wdata, mem_rdata;

    integer seed = 78477;
    logic [data_w-1:0] mem_words [logic [addr_w-1:0]];   // what memory holds
    logic [data_w-1:0] ref_words [logic [addr_w-1:0]];   // what the processor sees
    logic sh_valid [2][num_sets];
    logic sh_dirty [2][num_sets];
    logic [tag_w-1:0] sh_tag [2][num_sets];
    logic sh_mru [num_sets];
    int wb_count, rd_count;
    logic [addr_w-1:0] exp_wb_addr, exp_fill_addr, rd_addr;
    logic rd_pending;
    int rd_delay;

    cache_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [data_w-1:0] fill_pattern(input logic [addr_w-1:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic logic [data_w-1:0] mem_word(input logic [addr_w-1:0] a);
        return mem_words.exists(a) ? mem_words[a] : fill_pattern(a);
    endfunction

    function automatic logic [data_w-1:0] ref_word(input logic [addr_w-1:0] a);
        return ref_words.exists(a) ? ref_words[a] : fill_pattern(a);
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [line_w-1:0] got,
                         input logic [line_w-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run("value mismatch");
        end
    endtask

    // memory model with one transfer per accepted request
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_req_ready <= 1'b0;
            mem_resp_valid <= 1'b0;
            rd_pending = 1'b0;
        end else begin
            mem_req_ready <= ($random(seed) & 3) != 0;   // low about a quarter of the time
            mem_resp_valid <= 1'b0;
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req_write) begin
                    wb_count++;
                    check("mem_req_addr (write)", mem_req_addr, exp_wb_addr);
                    for (int w = 0; w < words_per_line; w++) begin
                        check("mem_wdata", mem_wdata[w*data_w +: data_w],
                              ref_word(mem_req_addr + 4 * w));
                        mem_words[mem_req_addr + 4 * w] = mem_wdata[w*data_w +: data_w];
                    end
                end else begin
                    rd_count++;
                    check("mem_req_addr (read)", mem_req_addr, exp_fill_addr);
                    rd_pending = 1'b1;
                    rd_addr = mem_req_addr;
                    rd_delay = ($random(seed) & 32'h7fff_ffff) % 5;
                end
            end
            if (rd_pending) begin
                if (rd_delay == 0) begin
                    mem_resp_valid <= 1'b1;
                    for (int w = 0; w < words_per_line; w++)
                        mem_rdata[w*data_w +: data_w] <= mem_word(rd_addr + 4 * w);
                    rd_pending = 1'b0;
                end else begin
                    rd_delay--;
                end
            end
        end
    end

    // drives one request through the handshake and checks it against the shadow model
    task automatic access(input logic wr, input logic [addr_w-1:0] addr,
                          input logic [data_w-1:0] wdata, output logic hit);
        logic [index_w-1:0] idx;
        logic [tag_w-1:0] tag;
        logic exp_hit, exp_wb;
        int hw, victim, cycles;
        idx = addr[offset_w +: index_w];
        tag = addr[addr_w-1 -: tag_w];
        exp_hit = 1'b0;
        exp_wb = 1'b0;
        hw = 0;
        victim = 0;
        for (int w = 0; w < 2; w++) begin
            if (sh_valid[w][idx] && sh_tag[w][idx] == tag) begin
                exp_hit = 1'b1;
                hw = w;
            end
        end
        if (!exp_hit) begin
            if (!sh_valid[0][idx])
                victim = 0;
            else if (!sh_valid[1][idx])
                victim = 1;
            else
                victim = sh_mru[idx] ? 0 : 1;
            exp_wb = sh_valid[victim][idx] && sh_dirty[victim][idx];
            exp_wb_addr = {sh_tag[victim][idx], idx, {offset_w{1'b0}}};
            exp_fill_addr = {tag, idx, {offset_w{1'b0}}};
        end
        wb_count = 0;
        rd_count = 0;
        @(posedge clk);
        req_valid <= 1'b1;
        req_write <= wr;
        req_addr <= addr;
        req_wdata <= wdata;
        do @(negedge clk); while (!req_ready);
        @(posedge clk);                             // acceptance edge
        req_valid <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > max_wait)
                stop_run("no response from the cache within the wait limit");
        end while (!resp_valid);
        hit = resp_hit;
        check("resp_hit", resp_hit, exp_hit);
        check("resp_rdata", resp_rdata, wr ? wdata : ref_word(addr));
        if (exp_hit)
            check("hit latency", cycles, 1);
        check("write-back count", wb_count, exp_wb);
        check("fill count", rd_count, !exp_hit);
        if (exp_hit) begin
            sh_mru[idx] = hw[0];
            if (wr)
                sh_dirty[hw][idx] = 1'b1;
        end else begin
            sh_valid[victim][idx] = 1'b1;
            sh_tag[victim][idx] = tag;
            sh_dirty[victim][idx] = wr;
            sh_mru[idx] = victim[0];
        end
        if (wr)
            ref_words[addr] = wdata;
    endtask

    task automatic test_reset;
        @(negedge clk);
        check("req_ready", req_ready, 1'b1);
        check("resp_valid", resp_valid, 1'b0);
        check("mem_req_valid", mem_req_valid, 1'b0);
    endtask

    task automatic test_read_miss_hit;
        logic hit;
        access(1'b0, 32'h0001_2344, '0, hit);
        check("first read hit", hit, 1'b0);
        access(1'b0, 32'h0001_2344, '0, hit);
        check("second read hit", hit, 1'b1);
    endtask

    task automatic test_write_hit;
        logic hit;
        access(1'b1, 32'h0001_2348, 32'hcafe_f00d, hit);
        check("write hit", hit, 1'b1);
        access(1'b0, 32'h0001_2348, '0, hit);   // traffic counts checked inside
    endtask

    task automatic test_eviction;
        logic hit;
        access(1'b1, 32'h0004_0050, 32'h1111_0001, hit);   // tag A, set 5
        access(1'b1, 32'h0008_0054, 32'h2222_0002, hit);   // tag B
        access(1'b0, 32'h0004_0050, '0, hit);              // A becomes MRU
        access(1'b0, 32'h000c_0058, '0, hit);              // C evicts dirty B
        check("wb on third tag", wb_count, 1);
        access(1'b0, 32'h0008_0054, '0, hit);              // B back, dirty A out
        check("wb on return of B", wb_count, 1);
    endtask

    task automatic test_random;
        logic hit;
        logic [addr_w-1:0] a;
        logic wr;
        for (int n = 0; n < random_reqs; n++) begin
            a = {20'h0, 2'($random(seed)), 6'($random(seed) & 7), 2'($random(seed)), 2'b00};
            wr = $random(seed) & 1;
            access(wr, a, $random(seed), hit);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        mem_req_ready = 1'b0;
        mem_resp_valid = 1'b0;
        mem_rdata = '0;
        for (int s = 0; s < num_sets; s++) begin
            sh_valid[0][s] = 1'b0;
            sh_valid[1][s] = 1'b0;
            sh_dirty[0][s] = 1'b0;
            sh_dirty[1][s] = 1'b0;
            sh_mru[s] = 1'b1;                    // way 0 is evicted first
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_read_miss_hit();
        test_write_hit();
        test_eviction();
        test_random();
        $display("TEST RESULT: PASS");
        $finish;
    end

    // watchdog allows 40 cycles of worst-case latency per request
    initial begin
        #(total_reqs * 40 * clk_period);
        stop_run("watchdog timeout, the tests did not finish in time");
    end

endmodule

//--- verilog/cache_ctrl.sv
`timescale 1ns/10ps
// request FSM of the two-way cache: merges way hits, tracks LRU per set
// and runs write-back and refill against the line-wide memory port

module cache_ctrl
    import cache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    // processor side
    input  logic                  req_valid,
    input  logic                  req_write,
    input  logic [addr_w-1:0]     req_addr,
    input  logic [data_w-1:0]     req_wdata,
    output logic                  req_ready,
    output logic                  resp_valid,
    output logic [data_w-1:0]     resp_rdata,
    output logic                  resp_hit,

    // memory side
    output logic                  mem_req_valid,
    output logic                  mem_req_write,
    output logic [addr_w-1:0]     mem_req_addr,
    output logic [line_w-1:0]     mem_wdata,
    input  logic                  mem_req_ready,
    input  logic                  mem_resp_valid,
    input  logic [line_w-1:0]     mem_rdata,

    // way side
    output logic [index_w-1:0]    lookup_index,
    output logic [tag_w-1:0]      lookup_tag,
    output logic [word_sel_w-1:0] word_sel,
    output logic                  word_we0,
    output logic                  word_we1,
    output logic                  fill_we0,
    output logic                  fill_we1,
    output logic [data_w-1:0]     wr_word,
    output logic [line_w-1:0]     fill_line,
    input  logic                  hit0,
    input  logic                  hit1,
    input  logic                  dirty0,
    input  logic                  dirty1,
    input  logic [tag_w-1:0]      tag0,
    input  logic [tag_w-1:0]      tag1,
    input  logic [data_w-1:0]     rd_word0,
    input  logic [data_w-1:0]     rd_word1,
    input  logic [line_w-1:0]     rd_line0,
    input  logic [line_w-1:0]     rd_line1
);

    logic [state_w-1:0]  state;
    logic [num_sets-1:0] lru;          // per set, the way to evict next
    logic                req_write_q;
    logic [data_w-1:0]   req_wdata_q;

    logic                any_hit;
    logic                victim;
    logic                victim_dirty;
    logic [tag_w-1:0]    victim_tag;
    logic                access_cycle;
    logic                fill_done;

    // Ways only become valid through refill, and the first refill of a set goes
    // to way 0 since lru resets to 0. With way 1 still empty the bit then always
    // points at way 1, so the LRU bit alone covers the invalid-way cases.
    assign victim = lru[lookup_index];
    assign victim_dirty = victim ? dirty1 : dirty0;
    assign victim_tag = victim ? tag1 : tag0;

    assign any_hit = hit0 | hit1;
    assign access_cycle = ((state == st_lookup) && any_hit) || (state == st_finish);

    // read data back only after the read request has been accepted
    assign fill_done = (state == st_fill) && !mem_req_valid && mem_resp_valid;

    // processor side
    assign req_ready = (state == st_idle);
    assign resp_valid = access_cycle;
    assign resp_hit = (state == st_lookup) && any_hit;
    assign resp_rdata = req_write_q ? req_wdata_q : (hit1 ? rd_word1 : rd_word0);

    // way writes
    assign wr_word = req_wdata_q;
    assign word_we0 = access_cycle && req_write_q && hit0;
    assign word_we1 = access_cycle && req_write_q && hit1;
    assign fill_line = mem_rdata;
    assign fill_we0 = fill_done && !victim;
    assign fill_we1 = fill_done && victim;

    // memory request, derived from held state so it is stable under back-pressure
    assign mem_req_write = (state == st_wb);
    assign mem_req_addr = {mem_req_write ? victim_tag : lookup_tag,
                           lookup_index, {offset_w{1'b0}}};
    assign mem_wdata = victim ? rd_line1 : rd_line0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            mem_req_valid <= 1'b0;
            lru <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (req_valid) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (any_hit) begin
                        state <= st_idle;
                    end else begin
                        mem_req_valid <= 1'b1;
                        state <= victim_dirty ? st_wb : st_fill;
                    end
                end
                st_wb: begin
                    if (mem_req_ready) begin
                        state <= st_fill;      // valid stays up for the read
                    end
                end
                st_fill: begin
                    if (mem_req_valid && mem_req_ready) begin
                        mem_req_valid <= 1'b0;
                    end
                    if (fill_done) begin
                        state <= st_finish;
                    end
                end
                st_finish: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase

            // hit or the access after a fill; the other way becomes LRU
            if (access_cycle) begin
                lru[lookup_index] <= hit0;
            end
        end
    end

    // request capture on acceptance
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            lookup_index <= req_addr[offset_w +: index_w];
            lookup_tag <= req_addr[addr_w-1 -: tag_w];
            word_sel <= req_addr[offset_w-1 -: word_sel_w];
            req_write_q <= req_write;
            req_wdata_q <= req_wdata;
        end
    end

endmodule

//--- verilog/cache_pkg.sv
// geometry and FSM encoding shared by the cache RTL and its testbench
// import with cache_pkg::* in the module header

package cache_pkg;

    // processor side
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // line geometry
    localparam int line_bytes = 16;
    localparam int line_w = line_bytes * 8;        // 128 bits
    localparam int words_per_line = line_w / data_w;
    localparam int word_sel_w = $clog2(words_per_line);

    // address split: tag | index | offset
    localparam int offset_w = $clog2(line_bytes);  // byte offset in a line
    localparam int index_w = 6;
    localparam int tag_w = addr_w - index_w - offset_w;
    localparam int num_sets = 1 << index_w;

    // controller states
    localparam int state_w = 3;

    // idle: ready for a new request
    localparam logic [state_w-1:0] st_idle = 3'd0;

    // registered request, ways compare
    localparam logic [state_w-1:0] st_lookup = 3'd1;

    // dirty victim goes out to memory
    localparam logic [state_w-1:0] st_wb = 3'd2;

    // line read request and wait for data
    localparam logic [state_w-1:0] st_fill = 3'd3;

    // access the freshly filled line
    localparam logic [state_w-1:0] st_finish = 3'd4;

endpackage

//--- verilog/cache_top.sv
`timescale 1ns/10ps
// two-way write-back data cache, 32-bit processor port to a 16-byte line memory
// two cache_way blocks look up in parallel under one cache_ctrl

module cache_top
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // processor side
    input  logic              req_valid,
    input  logic              req_write,
    input  logic [addr_w-1:0] req_addr,
    input  logic [data_w-1:0] req_wdata,
    output logic              req_ready,
    output logic              resp_valid,
    output logic [data_w-1:0] resp_rdata,
    output logic              resp_hit,

    // memory side
    output logic              mem_req_valid,
    output logic              mem_req_write,
    output logic [addr_w-1:0] mem_req_addr,
    output logic [line_w-1:0] mem_wdata,
    input  logic              mem_req_ready,
    input  logic              mem_resp_valid,
    input  logic [line_w-1:0] mem_rdata
);

    logic [index_w-1:0]    lookup_index;
    logic [tag_w-1:0]      lookup_tag;
    logic [word_sel_w-1:0] word_sel;
    logic [data_w-1:0]     wr_word;
    logic [line_w-1:0]     fill_line;

    logic                  word_we0, word_we1;
    logic                  fill_we0, fill_we1;
    logic                  hit0, hit1;
    logic                  dirty0, dirty1;
    logic [tag_w-1:0]      tag0, tag1;
    logic [data_w-1:0]     rd_word0, rd_word1;
    logic [line_w-1:0]     rd_line0, rd_line1;

    cache_way way0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .word_sel     (word_sel),
        .word_we      (word_we0),
        .wr_word      (wr_word),
        .fill_we      (fill_we0),
        .fill_line    (fill_line),
        .hit          (hit0),
        .line_dirty   (dirty0),
        .line_tag     (tag0),
        .rd_word      (rd_word0),
        .rd_line      (rd_line0)
    );

    cache_way way1 (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .word_sel     (word_sel),
        .word_we      (word_we1),
        .wr_word      (wr_word),
        .fill_we      (fill_we1),
        .fill_line    (fill_line),
        .hit          (hit1),
        .line_dirty   (dirty1),
        .line_tag     (tag1),
        .rd_word      (rd_word1),
        .rd_line      (rd_line1)
    );

    cache_ctrl ctrl0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_write      (req_write),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .resp_rdata     (resp_rdata),
        .resp_hit       (resp_hit),
        .mem_req_valid  (mem_req_valid),
        .mem_req_write  (mem_req_write),
        .mem_req_addr   (mem_req_addr),
        .mem_wdata      (mem_wdata),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_rdata      (mem_rdata),
        .lookup_index   (lookup_index),
        .lookup_tag     (lookup_tag),
        .word_sel       (word_sel),
        .word_we0       (word_we0),
        .word_we1       (word_we1),
        .fill_we0       (fill_we0),
        .fill_we1       (fill_we1),
        .wr_word        (wr_word),
        .fill_line      (fill_line),
        .hit0           (hit0),
        .hit1           (hit1),
        .dirty0         (dirty0),
        .dirty1         (dirty1),
        .tag0           (tag0),
        .tag1           (tag1),
        .rd_word0       (rd_word0),
        .rd_word1       (rd_word1),
        .rd_line0       (rd_line0),
        .rd_line1       (rd_line1)
    );

endmodule

//--- verilog/cache_way.sv
`timescale 1ns/10ps
// one way of the cache: valid, dirty, tag and line storage per set
// lookup is combinational on the indexed entry, updates land on the clock edge

module cache_way
    import cache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [index_w-1:0]    lookup_index,
    input  logic [tag_w-1:0]      lookup_tag,
    input  logic [word_sel_w-1:0] word_sel,
    input  logic                  word_we,
    input  logic [data_w-1:0]     wr_word,
    input  logic                  fill_we,
    input  logic [line_w-1:0]     fill_line,
    output logic                  hit,
    output logic                  line_dirty,
    output logic [tag_w-1:0]      line_tag,
    output logic [data_w-1:0]     rd_word,
    output logic [line_w-1:0]     rd_line
);

    logic [num_sets-1:0] valid;
    logic [num_sets-1:0] dirty;
    logic [tag_w-1:0]    tag_mem [num_sets];
    logic [line_w-1:0]   line_mem [num_sets];

    logic                entry_valid;
    logic [tag_w-1:0]    entry_tag;
    logic [line_w-1:0]   entry_line;

    assign entry_valid = valid[lookup_index];
    assign entry_tag = tag_mem[lookup_index];
    assign entry_line = line_mem[lookup_index];

    // lookup side
    assign hit = entry_valid && (entry_tag == lookup_tag);
    assign line_dirty = dirty[lookup_index];  // only ever set on a valid line
    assign line_tag = entry_tag;
    assign rd_line = entry_line;
    assign rd_word = entry_line[word_sel*data_w +: data_w];

    // status bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
            dirty <= '0;
        end else begin
            if (fill_we) begin
                valid[lookup_index] <= 1'b1;
                dirty[lookup_index] <= 1'b0;   // fresh copy of memory
            end else if (word_we) begin
                dirty[lookup_index] <= 1'b1;
            end
        end
    end

    // tag array, written by refill only
    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[lookup_index] <= lookup_tag;
        end
    end

    // line array: whole line on refill, single word on store
    always_ff @(posedge clk) begin
        if (fill_we) begin
            line_mem[lookup_index] <= fill_line;
        end else if (word_we) begin
            line_mem[lookup_index][word_sel*data_w +: data_w] <= wr_word;
        end
    end

endmodule
